// File: rtl/lsu_macros.svh
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// The RAM window starts at LSU_RAM_BASE and spans LSU_RAM_WORDS 32-bit words.
`define LSU_RAM_BASE   32'h8000_0000
`define LSU_RAM_WORDS  256
`define LSU_MEM_WAIT   2

`define LSU_AXI_ID     4'd0
`define LSU_AXI_INCR   2'b01
`define LSU_AXI_OKAY   2'b00
`define LSU_AXI_SLVERR 2'b10

`endif

// File: rtl/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    typedef enum logic [1:0] {
        MEM_NONE  = 2'd0,
        MEM_LOAD  = 2'd1,
        MEM_STORE = 2'd2
    } mem_op_e;

    // The encoding matches AXI AxSIZE, so it can be sent on the bus unchanged.
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } mem_size_e;

    typedef struct packed {
        mem_op_e     op;
        mem_size_e   size;
        logic        sext;
        logic [4:0]  rd;
        logic [31:0] addr;
        logic [31:0] wdata;
    } lsu_req_t;

    typedef struct packed {
        logic [4:0]  rd;
        logic [31:0] data;
        logic        fault;
        logic        was_load;
    } lsu_resp_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [3:0]  id;
        logic [7:0]  len;
        logic [2:0]  size;
        logic [1:0]  burst;
    } axi_ar_t;

    typedef axi_ar_t axi_aw_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
        logic        last;
    } axi_w_t;

    typedef struct packed {
        logic [3:0] id;
        logic [1:0] resp;
    } axi_b_t;

    typedef struct packed {
        logic [31:0] data;
        logic [1:0]  resp;
        logic        last;
        logic [3:0]  id;
    } axi_r_t;

endpackage

`default_nettype wire

// File: rtl/lsu_store_align.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_store_align
    import lsu_pkg::*;
(
    input  mem_size_e   size,
    input  logic [1:0]  addr_off,
    input  logic [31:0] wdata,
    output logic [31:0] lane_data,
    output logic [3:0]  strb
);

    // Requests are naturally aligned, so the shift never pushes bytes off the top.
    assign lane_data = wdata << {addr_off, 3'b000};

    always_comb begin
        case (size)
            SIZE_BYTE: strb = 4'b0001 << addr_off;
            SIZE_HALF: strb = 4'b0011 << addr_off;
            SIZE_WORD: strb = 4'b1111;
            default:   strb = 4'b0000;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/lsu_load_extend.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_load_extend
    import lsu_pkg::*;
(
    input  mem_size_e   size,
    input  logic        sext,
    input  logic [1:0]  addr_off,
    input  logic [31:0] rdata,
    output logic [31:0] value
);

    logic [31:0] shifted;

    assign shifted = rdata >> {addr_off, 3'b000};

    always_comb begin
        case (size)
            SIZE_BYTE: value = {{24{sext & shifted[7]}}, shifted[7:0]};
            SIZE_HALF: value = {{16{sext & shifted[15]}}, shifted[15:0]};
            default:   value = shifted;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/lsu.sv
`timescale 1ns/1ps
`default_nettype none
`include "lsu_macros.svh"

module lsu
    import lsu_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      req_valid,
    output logic      req_ready,
    input  lsu_req_t  req,
    output logic      resp_valid,
    input  logic      resp_ready,
    output lsu_resp_t resp,
    output logic      arvalid,
    input  logic      arready,
    output axi_ar_t   ar,
    output logic      awvalid,
    input  logic      awready,
    output axi_aw_t   aw,
    output logic      wvalid,
    input  logic      wready,
    output axi_w_t    w,
    input  logic      bvalid,
    output logic      bready,
    input  axi_b_t    b,
    input  logic      rvalid,
    output logic      rready,
    input  axi_r_t    r
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,
        ST_WAIT,
        ST_RESP
    } state_e;

    state_e      state;
    lsu_req_t    req_q;
    lsu_resp_t   resp_q;
    logic        is_load;
    logic        aw_done;
    logic        w_done;
    logic [31:0] lane_data;
    logic [3:0]  lane_strb;
    logic [31:0] load_value;

    lsu_store_align store_align_i (
        .size     (req_q.size),
        .addr_off (req_q.addr[1:0]),
        .wdata    (req_q.wdata),
        .lane_data(lane_data),
        .strb     (lane_strb)
    );

    lsu_load_extend load_extend_i (
        .size    (req_q.size),
        .sext    (req_q.sext),
        .addr_off(req_q.addr[1:0]),
        .rdata   (r.data),
        .value   (load_value)
    );

    assign is_load   = (req_q.op == MEM_LOAD);
    assign req_ready = (state == ST_IDLE);
    assign arvalid   = (state == ST_ADDR) && is_load;
    assign rready    = (state == ST_WAIT) && is_load;
    assign bready    = (state == ST_WAIT) && !is_load;
    assign resp      = resp_q;

    // Both address channels carry the same single-beat descriptor.
    assign ar = '{addr: req_q.addr, id: `LSU_AXI_ID, len: 8'd0,
                  size: {1'b0, req_q.size}, burst: `LSU_AXI_INCR};
    assign aw = ar;
    assign w  = '{data: lane_data, strb: lane_strb, last: 1'b1};

    // A channel counts as done once its valid has dropped or it handshakes now.
    assign aw_done = !awvalid || awready;
    assign w_done  = !wvalid || wready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= ST_IDLE;
            awvalid    <= 1'b0;
            wvalid     <= 1'b0;
            resp_valid <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (req_valid) begin
                        case (req.op)
                            MEM_LOAD: state <= ST_ADDR;
                            MEM_STORE: begin
                                awvalid <= 1'b1;
                                wvalid  <= 1'b1;
                                state   <= ST_ADDR;
                            end
                            default: begin
                                resp_valid <= 1'b1;
                                state      <= ST_RESP;
                            end
                        endcase
                    end
                end
                ST_ADDR: begin
                    if (is_load) begin
                        if (arready) begin
                            state <= ST_WAIT;
                        end
                    end else begin
                        if (awvalid && awready) begin
                            awvalid <= 1'b0;
                        end
                        if (wvalid && wready) begin
                            wvalid <= 1'b0;
                        end
                        if (aw_done && w_done) begin
                            state <= ST_WAIT;
                        end
                    end
                end
                ST_WAIT: begin
                    if (is_load ? rvalid : bvalid) begin
                        resp_valid <= 1'b1;
                        state      <= ST_RESP;
                    end
                end
                default: begin
                    if (resp_ready) begin
                        resp_valid <= 1'b0;
                        state      <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // A non-memory request answers with its own wdata, set here at acceptance.
    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            req_q           <= req;
            resp_q.rd       <= req.rd;
            resp_q.data     <= req.wdata;
            resp_q.fault    <= 1'b0;
            resp_q.was_load <= 1'b0;
        end else if (rvalid && rready) begin
            resp_q.data     <= load_value;
            resp_q.fault    <= (r.resp != `LSU_AXI_OKAY);
            resp_q.was_load <= 1'b1;
        end else if (bvalid && bready) begin
            resp_q.data  <= 32'd0;
            resp_q.fault <= (b.resp != `LSU_AXI_OKAY);
        end
    end

endmodule

`default_nettype wire

// File: rtl/axi_sram.sv
`timescale 1ns/1ps
`default_nettype none
`include "lsu_macros.svh"

module axi_sram
    import lsu_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    arvalid,
    output logic    arready,
    input  axi_ar_t ar,
    input  logic    awvalid,
    output logic    awready,
    input  axi_aw_t aw,
    input  logic    wvalid,
    output logic    wready,
    input  axi_w_t  w,
    output logic    bvalid,
    input  logic    bready,
    output axi_b_t  b,
    output logic    rvalid,
    input  logic    rready,
    output axi_r_t  r
);

    localparam int IDX_W = $clog2(`LSU_RAM_WORDS);
    localparam int CNT_W = $clog2(`LSU_MEM_WAIT + 2);

    typedef enum logic [1:0] {
        S_IDLE,
        S_WAIT,
        S_RESP
    } state_e;

    state_e           state;
    logic [CNT_W-1:0] wait_cnt;
    logic             is_wr;
    logic             w_held;
    logic [31:0]      mem [`LSU_RAM_WORDS];
    logic [31:0]      addr_q;
    logic [3:0]       id_q;
    logic [31:0]      wdata_q;
    logic [3:0]       wstrb_q;
    logic [31:0]      rdata_q;
    logic [1:0]       resp_q;
    logic [31:0]      offset;
    logic             in_window;
    logic [IDX_W-1:0] idx;
    logic             fire;

    // Addresses below the base wrap to a large offset and fall outside too.
    assign offset    = addr_q - `LSU_RAM_BASE;
    assign in_window = (offset < (`LSU_RAM_WORDS * 4));
    assign idx       = offset[IDX_W+1:2];

    // A write completes only once its data beat has also arrived.
    assign fire = (state == S_WAIT) && (wait_cnt == '0) && (!is_wr || w_held);

    assign arready = (state == S_IDLE);
    assign awready = (state == S_IDLE) && !arvalid;
    assign wready  = !w_held;
    assign rvalid  = (state == S_RESP) && !is_wr;
    assign bvalid  = (state == S_RESP) && is_wr;
    assign r       = '{data: rdata_q, resp: resp_q, last: 1'b1, id: id_q};
    assign b       = '{id: id_q, resp: resp_q};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= S_IDLE;
            wait_cnt <= '0;
            is_wr    <= 1'b0;
            w_held   <= 1'b0;
        end else begin
            if (wvalid && wready) begin
                w_held <= 1'b1;
            end else if (bvalid && bready) begin
                w_held <= 1'b0;
            end
            case (state)
                S_IDLE: begin
                    if (arvalid || awvalid) begin
                        is_wr    <= !arvalid;
                        wait_cnt <= CNT_W'(`LSU_MEM_WAIT);
                        state    <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (wait_cnt != '0) begin
                        wait_cnt <= wait_cnt - 1'b1;
                    end else if (fire) begin
                        state <= S_RESP;
                    end
                end
                default: begin
                    if (is_wr ? bready : rready) begin
                        state <= S_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (arvalid && arready) begin
            addr_q <= ar.addr;
            id_q   <= ar.id;
        end else if (awvalid && awready) begin
            addr_q <= aw.addr;
            id_q   <= aw.id;
        end
        if (wvalid && wready) begin
            wdata_q <= w.data;
            wstrb_q <= w.strb;
        end
        if (fire) begin
            resp_q <= in_window ? `LSU_AXI_OKAY : `LSU_AXI_SLVERR;
            if (!is_wr) begin
                rdata_q <= in_window ? mem[idx] : 32'd0;
            end else if (in_window) begin
                for (int i = 0; i < 4; i++) begin
                    if (wstrb_q[i]) begin
                        mem[idx][8*i +: 8] <= wdata_q[8*i +: 8];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_top
    import lsu_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      req_valid,
    output logic      req_ready,
    input  lsu_req_t  req,
    output logic      resp_valid,
    input  logic      resp_ready,
    output lsu_resp_t resp
);

    logic    arvalid;
    logic    arready;
    axi_ar_t ar;
    logic    awvalid;
    logic    awready;
    axi_aw_t aw;
    logic    wvalid;
    logic    wready;
    axi_w_t  w;
    logic    bvalid;
    logic    bready;
    axi_b_t  b;
    logic    rvalid;
    logic    rready;
    axi_r_t  r;

    lsu lsu_i (
        .clk, .rst,
        .req_valid, .req_ready, .req,
        .resp_valid, .resp_ready, .resp,
        .arvalid, .arready, .ar,
        .awvalid, .awready, .aw,
        .wvalid, .wready, .w,
        .bvalid, .bready, .b,
        .rvalid, .rready, .r
    );

    axi_sram sram_i (
        .clk, .rst,
        .arvalid, .arready, .ar,
        .awvalid, .awready, .aw,
        .wvalid, .wready, .w,
        .bvalid, .bready, .b,
        .rvalid, .rready, .r
    );

endmodule

`default_nettype wire

// File: testbench/tb_lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_lsu_top
    import lsu_pkg::*;
();

    localparam int CLK_PERIOD = 20;
    localparam int TIMEOUT    = 200;

    logic        clk;
    logic        rst;
    logic        req_valid;
    logic        req_ready;
    lsu_req_t    req;
    logic        resp_valid;
    logic        resp_ready;
    lsu_resp_t   resp;
    logic [15:0] lfsr;
    int          resp_count;
    int          test_count;

    lsu_top dut_i (
        .clk, .rst,
        .req_valid, .req_ready, .req,
        .resp_valid, .resp_ready, .resp
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // Every response transfer on the port is counted here, as the DUT sees it.
    always @(posedge clk) begin
        if (resp_valid && resp_ready) begin
            resp_count = resp_count + 1;
        end
    end

    // Taps 16, 14, 13 and 11 give a maximal-length sequence.
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1, "run aborted");
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s = %b, expected %b", $time, name, got, exp);
            $display("Simulation failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_resp(input string name, input lsu_resp_t got, input lsu_resp_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
            $display("Simulation failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic send_req(input lsu_req_t t);
        int cycles;
        cycles = 0;
        @(posedge clk);
        req_valid  <= 1'b1;
        req        <= t;
        resp_ready <= 1'b0;
        @(negedge clk);
        while (!req_ready) begin
            if (cycles == TIMEOUT) begin
                stop_on_error("Timed out waiting for the unit to accept a request.");
            end
            cycles++;
            @(negedge clk);
        end
        // The request transfers on this edge.
        @(posedge clk);
        req_valid <= 1'b0;
        @(negedge clk);
        check_bit("req_ready after accept", req_ready, 1'b0);
        if (t.op == MEM_NONE) begin
            check_bit("resp_valid after non-memory accept", resp_valid, 1'b1);
        end
    endtask

    task automatic wait_resp(input lsu_resp_t exp);
        lsu_resp_t held;
        logic      seen;
        logic      done;
        int        cycles;
        seen   = 1'b0;
        done   = 1'b0;
        cycles = 0;
        while (!done) begin
            if (cycles == TIMEOUT) begin
                stop_on_error("Timed out waiting for a response to be taken.");
            end
            cycles++;
            @(posedge clk);
            lfsr = lfsr_step(lfsr);
            resp_ready <= lfsr[0];
            @(negedge clk);
            if (resp_valid) begin
                if (!seen) begin
                    held = resp;
                    seen = 1'b1;
                end
                check_resp("resp while pending", resp, held);
                check_bit("req_ready while responding", req_ready, 1'b0);
                if (resp_ready) begin
                    check_resp("resp", resp, exp);
                    done = 1'b1;
                end
            end
        end
    endtask

    initial begin
        int          fd;
        int          n;
        string       line;
        logic [31:0] f_op;
        logic [31:0] f_size;
        logic [31:0] f_sext;
        logic [31:0] f_rd;
        logic [31:0] f_addr;
        logic [31:0] f_wdata;
        logic [31:0] f_data;
        logic [31:0] f_fault;
        lsu_req_t    t;
        lsu_resp_t   exp;

        rst        = 1'b1;
        req_valid  = 1'b0;
        req        = '0;
        resp_ready = 1'b0;
        lfsr       = 16'd51428;
        resp_count = 0;
        test_count = 0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_bit("req_ready after reset", req_ready, 1'b1);
        check_bit("resp_valid after reset", resp_valid, 1'b0);

        fd = $fopen("testbench/lsu_tests.txt", "r");
        if (fd == 0) begin
            stop_on_error("Could not open the test vector file.");
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 0 && line[0] != 8'h23) begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h", f_op, f_size, f_sext,
                            f_rd, f_addr, f_wdata, f_data, f_fault);
                if (n == 8) begin
                    t.op         = mem_op_e'(f_op[1:0]);
                    t.size       = mem_size_e'(f_size[1:0]);
                    t.sext       = f_sext[0];
                    t.rd         = f_rd[4:0];
                    t.addr       = f_addr;
                    t.wdata      = f_wdata;
                    exp.rd       = f_rd[4:0];
                    exp.data     = f_data;
                    exp.fault    = f_fault[0];
                    exp.was_load = (t.op == MEM_LOAD);
                    test_count++;
                    send_req(t);
                    wait_resp(exp);
                end else if (n > 0) begin
                    stop_on_error("A line in the test vector file is malformed.");
                end
            end
        end
        $fclose(fd);

        // The last response transfers on the next edge.
        @(posedge clk);
        @(negedge clk);

        if (test_count > 0 && resp_count == test_count) begin
            $display("Simulation passed");
            $finish;
        end else begin
            $display("Expected %0d responses, got %0d.", test_count, resp_count);
            $display("Simulation failed");
            $fatal(1, "response count mismatch");
        end
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+rtl
rtl/lsu_pkg.sv
rtl/lsu_store_align.sv
rtl/lsu_load_extend.sv
rtl/lsu.sv
rtl/axi_sram.sv
rtl/lsu_top.sv
testbench/tb_lsu_top.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
LINTFLAGS ?= --lint-only -Wall --timing
TOP       := tb_lsu_top
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Simulation passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: testbench/lsu_tests.txt
# op size sext rd addr wdata exp_data exp_fault, all fields in hex
# op: 0 none, 1 load, 2 store; size: 0 byte, 1 half, 2 word
2 2 0 01 80000000 12345678 00000000 0
1 2 0 02 80000000 00000000 12345678 0
2 2 0 03 80000004 a1b2c3d4 00000000 0
2 0 0 04 80000004 000000ee 00000000 0
2 0 0 05 80000005 00000077 00000000 0
2 0 0 06 80000006 00000099 00000000 0
2 0 0 07 80000007 00000080 00000000 0
1 2 0 08 80000004 00000000 809977ee 0
1 0 1 09 80000004 00000000 ffffffee 0
1 0 0 0a 80000007 00000000 00000080 0
1 0 1 0b 80000007 00000000 ffffff80 0
1 0 1 0c 80000005 00000000 00000077 0
2 2 0 0d 80000008 00000000 00000000 0
2 1 0 0e 8000000a 0000beef 00000000 0
2 1 0 0f 80000008 00001234 00000000 0
1 2 0 10 80000008 00000000 beef1234 0
1 1 1 11 8000000a 00000000 ffffbeef 0
1 1 0 12 8000000a 00000000 0000beef 0
1 1 1 13 80000008 00000000 00001234 0
2 2 0 14 80000400 deadbeef 00000000 1
1 2 0 15 80000400 00000000 00000000 1
1 2 0 16 80000000 00000000 12345678 0
2 0 0 17 7ffffffc 000000aa 00000000 1
1 2 1 18 7ffffffc 00000000 00000000 1
0 0 0 19 00000000 cafef00d cafef00d 0
0 2 1 1f 80000010 5a5aa5a5 5a5aa5a5 0
